// ==== logic/loader_pkg.sv ====
package loader_pkg;

    localparam int MEM_DEPTH  = 64;
    localparam int ADDR_W     = $clog2(MEM_DEPTH);
    localparam int FIFO_DEPTH = 16;
    localparam int IDLE_LIMIT = 16;

    typedef logic [7:0]                    byte_t;
    typedef logic [ADDR_W-1:0]             addr_t;
    // extra top bit so a completely full memory can still be counted
    typedef logic [ADDR_W:0]               count_t;
    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH):0]   fifo_cnt_t;
    typedef logic [$clog2(IDLE_LIMIT)-1:0] idle_cnt_t;
    typedef logic [1:0]                    opcode_t;

    localparam byte_t MARK_PROG = 8'h99;
    localparam byte_t MARK_DATA = 8'haa;

    localparam opcode_t OP_ADD  = 2'd0;
    localparam opcode_t OP_SUB  = 2'd1;
    localparam opcode_t OP_XOR  = 2'd2;
    localparam opcode_t OP_LOAD = 2'd3;

    typedef enum logic [2:0] {
        INIT,
        WRITE_99,
        PROGRAM_RECEIVE,
        WRITE_AA,
        DATA_RECEIVE,
        EXEC,
        RESULT_WRITE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SEL_PROG_MARK,
        SEL_DATA_MARK,
        SEL_RESULT
    } tx_sel_t;

    typedef struct packed {
        opcode_t op;
        addr_t   operand;
    } instr_t;

    typedef struct packed {
        logic  imem_we;
        logic  dmem_we;
        byte_t data;
    } mem_wr_t;

endpackage

// ==== logic/rx_gap_detect.sv ====
`timescale 1ns/10ps

module rx_gap_detect (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_valid,
    input  loader_pkg::byte_t rx_data,
    input  logic              rx_enable,
    output logic              rx_accept,
    output loader_pkg::byte_t rx_byte,
    output logic              rx_timeout
);

    loader_pkg::idle_cnt_t idle_cnt;
    logic                  armed;
    logic                  enable_q;

    // bytes only count while the controller listens
    assign rx_accept = rx_valid && rx_enable;
    assign rx_byte   = rx_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_cnt   <= '0;
            armed      <= 1'b0;
            enable_q   <= 1'b0;
            rx_timeout <= 1'b0;
        end else begin
            enable_q   <= rx_enable;
            rx_timeout <= 1'b0;
            if (!rx_enable) begin
                armed    <= 1'b0;
                idle_cnt <= '0;
            end else if (rx_accept || !enable_q) begin
                // restart the gap on enable rise or on any byte
                armed    <= 1'b1;
                idle_cnt <= '0;
            end else if (armed) begin
                if (idle_cnt == loader_pkg::idle_cnt_t'(loader_pkg::IDLE_LIMIT - 1)) begin
                    rx_timeout <= 1'b1;
                    armed      <= 1'b0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/byte_fifo.sv ====
`timescale 1ns/10ps

module byte_fifo (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  loader_pkg::byte_t wr_data,
    input  logic              re,
    output loader_pkg::byte_t rd_data,
    output logic              empty
);

    loader_pkg::byte_t     mem [loader_pkg::FIFO_DEPTH];
    loader_pkg::fifo_ptr_t wr_ptr;
    loader_pkg::fifo_ptr_t rd_ptr;
    loader_pkg::fifo_cnt_t count;
    loader_pkg::byte_t     rd_q;
    logic                  push;
    logic                  pop;

    assign empty = (count == '0);
    // writes into a full buffer are dropped
    assign push  = we && (count != loader_pkg::fifo_cnt_t'(loader_pkg::FIFO_DEPTH));
    assign pop   = re && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and the two read stages, block ram style
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
        if (pop) begin
            rd_q <= mem[rd_ptr];
        end
        rd_data <= rd_q;
    end

endmodule

// ==== logic/io_fsm.sv ====
`timescale 1ns/10ps

module io_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                fifo_empty,
    input  logic                rx_accept,
    input  logic                rx_timeout,
    input  logic                init_done,
    input  logic                exec_done,
    input  logic                tx_ack,
    output logic                rx_enable,
    output logic                fifo_we,
    output logic                fifo_re,
    output loader_pkg::mem_wr_t mem_wr,
    output logic                clear_start,
    output logic                core_run,
    output logic                tx_req,
    output loader_pkg::tx_sel_t tx_sel
);

    loader_pkg::ctrl_state_t state;
    loader_pkg::ctrl_state_t n_state;
    logic [1:0]              empty_pipe;
    logic                    rd_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= loader_pkg::INIT;
            empty_pipe <= 2'b11;
        end else begin
            state <= n_state;
            // a cycle without a read counts as empty
            empty_pipe <= {empty_pipe[0], fifo_empty || !fifo_re};
        end
    end

    // fifo output lags the read enable by two cycles
    assign rd_valid = !empty_pipe[1];

    always_comb begin
        case (state)
            loader_pkg::INIT:
                n_state = init_done ? loader_pkg::WRITE_99 : loader_pkg::INIT;
            loader_pkg::WRITE_99:
                n_state = tx_ack ? loader_pkg::PROGRAM_RECEIVE : loader_pkg::WRITE_99;
            loader_pkg::PROGRAM_RECEIVE:
                n_state = rx_timeout ? loader_pkg::WRITE_AA : loader_pkg::PROGRAM_RECEIVE;
            loader_pkg::WRITE_AA:
                n_state = tx_ack ? loader_pkg::DATA_RECEIVE : loader_pkg::WRITE_AA;
            loader_pkg::DATA_RECEIVE:
                n_state = rx_timeout ? loader_pkg::EXEC : loader_pkg::DATA_RECEIVE;
            loader_pkg::EXEC:
                n_state = exec_done ? loader_pkg::RESULT_WRITE : loader_pkg::EXEC;
            loader_pkg::RESULT_WRITE:
                n_state = tx_ack ? loader_pkg::INIT : loader_pkg::RESULT_WRITE;
            default:
                n_state = loader_pkg::INIT;
        endcase
    end

    always_comb begin
        rx_enable   = 1'b0;
        fifo_re     = 1'b0;
        tx_req      = 1'b0;
        tx_sel      = loader_pkg::SEL_RESULT;
        core_run    = 1'b0;
        clear_start = 1'b0;
        mem_wr      = '0;
        case (state)
            loader_pkg::WRITE_99: begin
                tx_req    = 1'b1;
                tx_sel    = loader_pkg::SEL_PROG_MARK;
                // open the receive path as the marker is acknowledged
                rx_enable = tx_ack;
                fifo_re   = tx_ack;
            end
            loader_pkg::PROGRAM_RECEIVE: begin
                rx_enable      = !rx_timeout;
                fifo_re        = !rx_timeout;
                mem_wr.imem_we = rd_valid;
            end
            loader_pkg::WRITE_AA: begin
                tx_req    = 1'b1;
                tx_sel    = loader_pkg::SEL_DATA_MARK;
                rx_enable = tx_ack;
                fifo_re   = tx_ack;
            end
            loader_pkg::DATA_RECEIVE: begin
                rx_enable      = !rx_timeout;
                fifo_re        = !rx_timeout;
                mem_wr.dmem_we = rd_valid;
            end
            loader_pkg::EXEC: begin
                core_run = 1'b1;
            end
            loader_pkg::RESULT_WRITE: begin
                tx_req      = 1'b1;
                clear_start = tx_ack;
            end
            default: begin
                tx_req = 1'b0;
            end
        endcase
    end

    // every accepted byte goes straight into the fifo
    assign fifo_we = rx_accept;

endmodule

// ==== logic/load_store.sv ====
`timescale 1ns/10ps

module load_store (
    input  logic                clk,
    input  logic                rst,
    input  loader_pkg::mem_wr_t mem_wr,
    input  loader_pkg::byte_t   wr_byte,
    input  logic                clear_start,
    output logic                init_done,
    output loader_pkg::count_t  prog_len,
    input  loader_pkg::addr_t   imem_addr,
    output loader_pkg::instr_t  imem_word,
    input  loader_pkg::addr_t   dmem_addr,
    output loader_pkg::byte_t   dmem_word
);

    loader_pkg::instr_t  imem [loader_pkg::MEM_DEPTH];
    loader_pkg::byte_t   dmem [loader_pkg::MEM_DEPTH];
    loader_pkg::count_t  imem_ptr;
    loader_pkg::count_t  dmem_ptr;
    loader_pkg::addr_t   clr_addr;
    loader_pkg::byte_t   wr_data_q;
    logic                imem_we_q;
    logic                dmem_we_q;
    logic                clearing;

    // write enables, pointers and the clear sweep
    always_ff @(posedge clk) begin
        if (rst || clear_start) begin
            imem_we_q <= 1'b0;
            dmem_we_q <= 1'b0;
            imem_ptr  <= '0;
            dmem_ptr  <= '0;
            clearing  <= 1'b1;
            clr_addr  <= '0;
            init_done <= 1'b0;
        end else begin
            imem_we_q <= mem_wr.imem_we;
            dmem_we_q <= mem_wr.dmem_we;
            init_done <= 1'b0;
            // stop counting once the top bit says full
            if (imem_we_q && !imem_ptr[loader_pkg::ADDR_W]) begin
                imem_ptr <= imem_ptr + 1'b1;
            end
            if (dmem_we_q && !dmem_ptr[loader_pkg::ADDR_W]) begin
                dmem_ptr <= dmem_ptr + 1'b1;
            end
            if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == loader_pkg::addr_t'(loader_pkg::MEM_DEPTH - 1)) begin
                    clearing  <= 1'b0;
                    init_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data_q <= mem_wr.data;
        if (imem_we_q && !imem_ptr[loader_pkg::ADDR_W]) begin
            imem[imem_ptr[loader_pkg::ADDR_W-1:0]] <= loader_pkg::instr_t'(wr_data_q);
        end
        // sweep fills with wr_byte, otherwise the next data slot
        if (clearing) begin
            dmem[clr_addr] <= wr_byte;
        end else if (dmem_we_q && !dmem_ptr[loader_pkg::ADDR_W]) begin
            dmem[dmem_ptr[loader_pkg::ADDR_W-1:0]] <= wr_data_q;
        end
    end

    assign prog_len  = imem_ptr;
    assign imem_word = imem[imem_addr];
    assign dmem_word = dmem[dmem_addr];

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               core_run,
    input  loader_pkg::count_t prog_len,
    output loader_pkg::addr_t  imem_addr,
    input  loader_pkg::instr_t imem_word,
    output loader_pkg::addr_t  dmem_addr,
    input  loader_pkg::byte_t  dmem_word,
    output logic               exec_done,
    output loader_pkg::byte_t  result
);

    loader_pkg::count_t pc;
    loader_pkg::byte_t  acc;
    loader_pkg::byte_t  acc_next;
    logic               busy;
    logic               step;

    assign imem_addr = pc[loader_pkg::ADDR_W-1:0];
    assign dmem_addr = imem_word.operand;
    assign step      = core_run && busy && (pc != prog_len);
    // one pulse, since core_run drops right after it
    assign exec_done = core_run && busy && (pc == prog_len);
    assign result    = acc;

    always_comb begin
        case (imem_word.op)
            loader_pkg::OP_ADD:  acc_next = acc + dmem_word;
            loader_pkg::OP_SUB:  acc_next = acc - dmem_word;
            loader_pkg::OP_XOR:  acc_next = acc ^ dmem_word;
            loader_pkg::OP_LOAD: acc_next = dmem_word;
            default:             acc_next = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            pc   <= '0;
        end else if (!core_run) begin
            busy <= 1'b0;
        end else if (!busy) begin
            // first run cycle only sets up
            busy <= 1'b1;
            pc   <= '0;
        end else if (step) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (core_run && !busy) begin
            acc <= '0;
        end else if (step) begin
            acc <= acc_next;
        end
    end

endmodule

// ==== logic/loader_top.sv ====
`timescale 1ns/10ps

module loader_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_valid,
    input  loader_pkg::byte_t rx_data,
    input  logic              tx_ack,
    output logic              tx_req,
    output loader_pkg::byte_t tx_data
);

    loader_pkg::byte_t   rx_byte;
    loader_pkg::byte_t   fifo_rd_data;
    loader_pkg::byte_t   result;
    loader_pkg::mem_wr_t fsm_wr;
    loader_pkg::mem_wr_t ls_wr;
    loader_pkg::count_t  prog_len;
    loader_pkg::addr_t   imem_addr;
    loader_pkg::addr_t   dmem_addr;
    loader_pkg::instr_t  imem_word;
    loader_pkg::byte_t   dmem_word;
    loader_pkg::tx_sel_t tx_sel;
    logic                rx_enable;
    logic                rx_accept;
    logic                rx_timeout;
    logic                fifo_we;
    logic                fifo_re;
    logic                fifo_empty;
    logic                clear_start;
    logic                init_done;
    logic                core_run;
    logic                exec_done;

    rx_gap_detect i_rx_gap_detect (
        .clk, .rst, .rx_valid, .rx_data, .rx_enable, .rx_accept, .rx_byte, .rx_timeout
    );

    byte_fifo i_byte_fifo (
        .clk, .rst, .we(fifo_we), .wr_data(rx_byte), .re(fifo_re),
        .rd_data(fifo_rd_data), .empty(fifo_empty)
    );

    io_fsm i_io_fsm (
        .clk, .rst, .fifo_empty, .rx_accept, .rx_timeout, .init_done, .exec_done, .tx_ack,
        .rx_enable, .fifo_we, .fifo_re, .mem_wr(fsm_wr), .clear_start, .core_run,
        .tx_req, .tx_sel
    );

    // controller enables carry the fifo byte along
    assign ls_wr = '{imem_we: fsm_wr.imem_we, dmem_we: fsm_wr.dmem_we,
                     data: fifo_rd_data};

    load_store i_load_store (
        .clk, .rst, .mem_wr(ls_wr), .wr_byte(loader_pkg::byte_t'(0)), .clear_start,
        .init_done, .prog_len, .imem_addr, .imem_word, .dmem_addr, .dmem_word
    );

    exec_unit i_exec_unit (
        .clk, .rst, .core_run, .prog_len, .imem_addr, .imem_word, .dmem_addr, .dmem_word,
        .exec_done, .result
    );

    always_comb begin
        case (tx_sel)
            loader_pkg::SEL_PROG_MARK: tx_data = loader_pkg::MARK_PROG;
            loader_pkg::SEL_DATA_MARK: tx_data = loader_pkg::MARK_DATA;
            default:                   tx_data = result;
        endcase
    end

endmodule

// ==== verification/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/tb_loader_top.sv ====
`timescale 1ns/10ps

module tb_loader_top;

    // three runs of roughly 400 cycles each, slow acks included, plus wide margin
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam int          MAX_GAP        = 7;
    localparam int          MAX_ACK_DELAY  = 5;
    localparam logic [31:0] SEED           = 32'h44f1ac68;

    logic              clk;
    logic              rst;
    logic              rx_valid;
    loader_pkg::byte_t rx_data;
    logic              tx_ack;
    logic              tx_req;
    loader_pkg::byte_t tx_data;

    loader_pkg::byte_t exp_q[$];
    string             name_q[$];
    int                checks = 0;
    int                mismatches = 0;
    int                other_errs = 0;
    int                cycle_cnt;
    logic              req_q = 1'b0;
    logic              ack_q = 1'b0;
    loader_pkg::byte_t data_q;

    clk_gen i_clk_gen (.clk, .rst);

    loader_top i_loader_top (
        .clk, .rst, .rx_valid, .rx_data, .tx_ack, .tx_req, .tx_data
    );

    function automatic loader_pkg::byte_t ref_run(input loader_pkg::byte_t prog[$],
                                                  input loader_pkg::byte_t data[$]);
        loader_pkg::byte_t acc;
        loader_pkg::byte_t val;
        int                addr;
        acc = 8'h00;
        foreach (prog[i]) begin
            addr = int'(prog[i][5:0]);
            // unloaded data words read as zero after the clear
            val = (addr < data.size()) ? data[addr] : 8'h00;
            case (prog[i][7:6])
                2'd0:    acc = acc + val;
                2'd1:    acc = acc - val;
                2'd2:    acc = acc ^ val;
                default: acc = val;
            endcase
        end
        return acc;
    endfunction

    task automatic send_bytes(input loader_pkg::byte_t q[$]);
        int gap;
        foreach (q[i]) begin
            // gaps stay well below the idle limit
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) begin
                @(posedge clk);
                rx_valid <= 1'b0;
            end
            @(posedge clk);
            rx_valid <= 1'b1;
            rx_data  <= q[i];
        end
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    // wait for a tx request, then acknowledge it after a random delay
    task automatic answer_request(input int min_quiet);
        int quiet;
        int delay;
        quiet = 0;
        @(negedge clk);
        while (tx_req !== 1'b1) begin
            quiet++;
            @(negedge clk);
        end
        checks++;
        assert (quiet >= min_quiet)
        else begin
            other_errs++;
            $display("tx_req rose after %0d quiet cycles, at least %0d expected",
                     quiet, min_quiet);
        end
        delay = $urandom_range(0, MAX_ACK_DELAY);
        repeat (delay) @(negedge clk);
        @(posedge clk);
        tx_ack <= 1'b1;
        @(posedge clk);
        tx_ack <= 1'b0;
    endtask

    task automatic load_and_run(input string name, input int n_prog, input int n_data);
        loader_pkg::byte_t prog[$];
        loader_pkg::byte_t data[$];
        int                op;
        int                opd;
        for (int i = 0; i < n_prog; i++) begin
            op  = $urandom_range(0, 3);
            // low operands, so short data sets still get read
            opd = $urandom_range(0, 23);
            prog.push_back({op[1:0], opd[5:0]});
        end
        for (int i = 0; i < n_data; i++) begin
            data.push_back(loader_pkg::byte_t'($urandom_range(0, 255)));
        end
        exp_q.push_back(loader_pkg::MARK_PROG);
        name_q.push_back({name, " prog marker"});
        exp_q.push_back(loader_pkg::MARK_DATA);
        name_q.push_back({name, " data marker"});
        exp_q.push_back(ref_run(prog, data));
        name_q.push_back({name, " result"});
        // the clear sweep keeps tx quiet for a full memory depth
        answer_request(loader_pkg::MEM_DEPTH);
        send_bytes(prog);
        answer_request(loader_pkg::IDLE_LIMIT);
        send_bytes(data);
        answer_request(loader_pkg::IDLE_LIMIT);
    endtask

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errs);
    endtask

    // tx monitor: byte order, hold while requested, drop after ack
    always @(negedge clk) begin
        if (rst) begin
            checks++;
            assert (tx_req == 1'b0)
            else begin
                other_errs++;
                $display("tx_req high during reset");
            end
        end else begin
            if (tx_req && !req_q) begin
                checks++;
                assert (exp_q.size() != 0)
                else begin
                    other_errs++;
                    $display("unexpected tx request carrying %02h", tx_data);
                end
                if (exp_q.size() != 0) begin
                    checks++;
                    assert (tx_data == exp_q[0])
                    else begin
                        mismatches++;
                        $display("MISMATCH %s: expected %02h, actual %02h",
                                 name_q[0], exp_q[0], tx_data);
                    end
                    void'(exp_q.pop_front());
                    void'(name_q.pop_front());
                end
            end
            if (req_q && !ack_q) begin
                checks += 2;
                assert (tx_req)
                else begin
                    other_errs++;
                    $display("tx_req fell without a tx_ack");
                end
                assert (!tx_req || tx_data == data_q)
                else begin
                    mismatches++;
                    $display("MISMATCH tx hold: expected %02h, actual %02h", data_q, tx_data);
                end
            end
            if (ack_q) begin
                checks++;
                assert (!tx_req)
                else begin
                    other_errs++;
                    $display("tx_req still high the cycle after tx_ack");
                end
            end
        end
        req_q  <= tx_req;
        ack_q  <= tx_ack;
        data_q <= tx_data;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        tx_ack   = 1'b0;
        while (rst !== 1'b0) @(posedge clk);
        load_and_run("run_full", 10, 20);
        load_and_run("run_no_data", 8, 0);
        // shorter data, so stale words from the first run must be cleared
        load_and_run("run_short_data", 10, 6);
        repeat (2) @(posedge clk);
        checks++;
        assert (exp_q.size() == 0)
        else begin
            other_errs++;
            $display("%0d expected tx bytes never appeared", exp_q.size());
        end
        print_counts();
        if (mismatches == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/loader_pkg.sv
logic/rx_gap_detect.sv
logic/byte_fifo.sv
logic/io_fsm.sv
logic/load_store.sv
logic/exec_unit.sv
logic/loader_top.sv
verification/clk_gen.sv
verification/tb_loader_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_loader_top -Mdir obj_dir -o sim_loader
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_loader > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1
